// File: hw/bank_pkg.sv
package bank_pkg;

  // Lane and bank word width, strobe types depend on it
  parameter int unsigned LaneDataWidth = 32;
  // Flat lane address carried between splitters and crossbar
  parameter int unsigned LaneAddrWidth = 16;

  typedef logic [LaneDataWidth-1:0]   lane_data_t;
  typedef logic [LaneDataWidth/8-1:0] lane_strb_t;

  // Address split rule
  //   lane address = wide address * lanes per port + lane index
  //   bank index   = lane address modulo number of banks
  //   bank row     = lane address divided by number of banks
  // Consecutive lanes of one wide word land in different banks

  function automatic logic [LaneAddrWidth-1:0] lane_addr(
    input logic [LaneAddrWidth-1:0] wide_addr,
    input int unsigned              lane,
    input int unsigned              lanes_per_port
  );
    return LaneAddrWidth'(wide_addr * lanes_per_port + lane);
  endfunction

  function automatic int unsigned bank_idx(
    input logic [LaneAddrWidth-1:0] addr,
    input int unsigned              num_banks
  );
    return addr % num_banks;
  endfunction

  function automatic logic [LaneAddrWidth-1:0] bank_row(
    input logic [LaneAddrWidth-1:0] addr,
    input int unsigned              num_banks
  );
    return LaneAddrWidth'(addr / num_banks);
  endfunction

endpackage

// File: hw/lane_if.sv
`timescale 1ns/1ns

interface lane_if;
  import bank_pkg::*;

  // Request side, held steady until gnt
  logic                     req;
  logic                     gnt;
  logic [LaneAddrWidth-1:0] addr;
  logic                     we;
  lane_data_t               wdata;
  lane_strb_t               strb;
  // Read return, one cycle after the grant
  logic                     rvalid;
  lane_data_t               rdata;

  // Splitter side
  modport initiator (
    output req, addr, we, wdata, strb,
    input  gnt, rvalid, rdata
  );

  // Crossbar side
  modport target (
    input  req, addr, we, wdata, strb,
    output gnt, rvalid, rdata
  );

endinterface

// File: hw/bank_sram.sv
`timescale 1ns/1ns

module bank_sram #(
  parameter int unsigned BankAddrWidth = 5
) (
  input  logic                     clk_i,
  input  logic                     req_i,
  input  logic                     we_i,
  input  logic [BankAddrWidth-1:0] row_i,
  input  bank_pkg::lane_data_t     wdata_i,
  input  bank_pkg::lane_strb_t     strb_i,
  output bank_pkg::lane_data_t     rdata_o
);
  import bank_pkg::*;

  // One word per row
  lane_data_t mem_q [2**BankAddrWidth];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        // Only strobed bytes change
        for (int i = 0; i < LaneDataWidth / 8; i++) begin
          if (strb_i[i]) begin
            mem_q[row_i][8*i +: 8] <= wdata_i[8*i +: 8];
          end
        end
      end else begin
        // Registered read, valid the next cycle
        rdata_o <= mem_q[row_i];
      end
    end
  end

endmodule

// File: hw/bank_xbar.sv
`timescale 1ns/1ns

module bank_xbar #(
  parameter int unsigned NumBanks      = 4,
  parameter int unsigned LanesPerPort  = 2,
  parameter int unsigned BankAddrWidth = 5
) (
  input  logic                                                   clk_i,
  input  logic                                                   rst_i,
  lane_if.target                                                 rd_lanes [LanesPerPort],
  lane_if.target                                                 wr_lanes [LanesPerPort],
  output logic                 [NumBanks-1:0]                    bank_req_o,
  output logic                 [NumBanks-1:0]                    bank_we_o,
  output logic                 [NumBanks-1:0][BankAddrWidth-1:0] bank_row_o,
  output bank_pkg::lane_data_t [NumBanks-1:0]                    bank_wdata_o,
  output bank_pkg::lane_strb_t [NumBanks-1:0]                    bank_strb_o,
  input  bank_pkg::lane_data_t [NumBanks-1:0]                    bank_rdata_i
);
  import bank_pkg::*;

  // Side 0 is the read port, side 1 the write port
  logic       [1:0][LanesPerPort-1:0]                    lane_req;
  logic       [1:0][LanesPerPort-1:0]                    lane_we;
  logic       [1:0][LanesPerPort-1:0]                    lane_gnt;
  logic       [1:0][LanesPerPort-1:0][LaneAddrWidth-1:0] lane_addr_in;
  lane_data_t [1:0][LanesPerPort-1:0]                    lane_wdata;
  lane_strb_t [1:0][LanesPerPort-1:0]                    lane_strb;
  logic       [LanesPerPort-1:0]                         rd_rvalid;
  lane_data_t [LanesPerPort-1:0]                         rd_rdata;

  // Per bank request matches, lowest matching lane per side, winning side
  logic [NumBanks-1:0][1:0][LanesPerPort-1:0] match;
  logic [NumBanks-1:0][1:0][LanesPerPort-1:0] pick;
  logic [NumBanks-1:0][1:0]                   side_gnt;
  // Round-robin pointer, set when the write side is favoured
  logic [NumBanks-1:0]                        rr_q;
  // Read lane granted on each bank last cycle
  logic [NumBanks-1:0][LanesPerPort-1:0]      ret_q;

  for (genvar l = 0; l < LanesPerPort; l++) begin : gen_lane_io
    assign lane_req[0][l]     = rd_lanes[l].req;
    assign lane_we[0][l]      = rd_lanes[l].we;
    assign lane_addr_in[0][l] = rd_lanes[l].addr;
    assign lane_wdata[0][l]   = rd_lanes[l].wdata;
    assign lane_strb[0][l]    = rd_lanes[l].strb;
    assign rd_lanes[l].gnt    = lane_gnt[0][l];
    assign rd_lanes[l].rvalid = rd_rvalid[l];
    assign rd_lanes[l].rdata  = rd_rdata[l];
    assign lane_req[1][l]     = wr_lanes[l].req;
    assign lane_we[1][l]      = wr_lanes[l].we;
    assign lane_addr_in[1][l] = wr_lanes[l].addr;
    assign lane_wdata[1][l]   = wr_lanes[l].wdata;
    assign lane_strb[1][l]    = wr_lanes[l].strb;
    assign wr_lanes[l].gnt    = lane_gnt[1][l];
    // Writes return nothing
    assign wr_lanes[l].rvalid = 1'b0;
    assign wr_lanes[l].rdata  = '0;
  end

  // Arbitration
  always_comb begin
    for (int unsigned b = 0; b < NumBanks; b++) begin
      for (int unsigned s = 0; s < 2; s++) begin
        for (int unsigned l = 0; l < LanesPerPort; l++) begin
          match[b][s][l] = lane_req[s][l] && (bank_idx(lane_addr_in[s][l], NumBanks) == b);
        end
        // Isolate lowest set bit
        pick[b][s] = match[b][s] & ~(match[b][s] - LanesPerPort'(1));
      end
      // Read wins unless write is favoured and waiting
      side_gnt[b][0] = (|match[b][0]) && (!(|match[b][1]) || !rr_q[b]);
      side_gnt[b][1] = (|match[b][1]) && !side_gnt[b][0];
    end
  end

  // Route the winner to its bank and grant it
  always_comb begin
    lane_gnt     = '0;
    bank_req_o   = '0;
    bank_we_o    = '0;
    bank_row_o   = '0;
    bank_wdata_o = '0;
    bank_strb_o  = '0;
    for (int unsigned b = 0; b < NumBanks; b++) begin
      bank_req_o[b] = |side_gnt[b];
      for (int unsigned s = 0; s < 2; s++) begin
        for (int unsigned l = 0; l < LanesPerPort; l++) begin
          if (side_gnt[b][s] && pick[b][s][l]) begin
            lane_gnt[s][l]  = 1'b1;
            bank_we_o[b]    = lane_we[s][l];
            bank_row_o[b]   = BankAddrWidth'(bank_row(lane_addr_in[s][l], NumBanks));
            bank_wdata_o[b] = lane_wdata[s][l];
            bank_strb_o[b]  = lane_strb[s][l];
          end
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rr_q  <= '0;
      ret_q <= '0;
    end else begin
      for (int unsigned b = 0; b < NumBanks; b++) begin
        // Matches the one cycle bank read latency
        ret_q[b] <= side_gnt[b][0] ? pick[b][0] : '0;
        // Favour the side that lost
        if (side_gnt[b][0]) begin
          rr_q[b] <= 1'b1;
        end else if (side_gnt[b][1]) begin
          rr_q[b] <= 1'b0;
        end
      end
    end
  end

  // Steer bank read data back to the lane that asked
  always_comb begin
    rd_rvalid = '0;
    rd_rdata  = '0;
    for (int unsigned l = 0; l < LanesPerPort; l++) begin
      for (int unsigned b = 0; b < NumBanks; b++) begin
        if (ret_q[b][l]) begin
          rd_rvalid[l] = 1'b1;
          rd_rdata[l]  = bank_rdata_i[b];
        end
      end
    end
  end

endmodule

// File: hw/rd_splitter.sv
`timescale 1ns/1ns

module rd_splitter #(
  parameter int unsigned  LanesPerPort = 2,
  localparam int unsigned AddrWidth    = bank_pkg::LaneAddrWidth - $clog2(LanesPerPort)
) (
  input  logic                                            clk_i,
  input  logic                                            rst_i,
  input  logic                                            valid_i,
  output logic                                            ready_o,
  input  logic [AddrWidth-1:0]                            addr_i,
  output logic                                            rsp_valid_o,
  output logic [LanesPerPort*bank_pkg::LaneDataWidth-1:0] rsp_data_o,
  lane_if.initiator                                       lanes [LanesPerPort]
);
  import bank_pkg::*;

  logic [AddrWidth-1:0]          addr_q;
  // Lanes still waiting for a grant
  logic [LanesPerPort-1:0]       pend_q;
  // Lanes still waiting for data
  logic [LanesPerPort-1:0]       wait_q;
  logic [LanesPerPort-1:0]       gnt;
  logic [LanesPerPort-1:0]       rvalid;
  lane_data_t [LanesPerPort-1:0] rdata;
  lane_data_t [LanesPerPort-1:0] data_q;
  logic                          rsp_valid_q;
  logic                          xfer;

  // Idle once every lane has returned
  assign ready_o = ~|wait_q;
  assign xfer    = valid_i & ready_o;

  for (genvar l = 0; l < LanesPerPort; l++) begin : gen_lane
    assign lanes[l].req   = pend_q[l];
    assign lanes[l].we    = 1'b0;
    assign lanes[l].addr  = lane_addr(LaneAddrWidth'(addr_q), l, LanesPerPort);
    assign lanes[l].wdata = '0;
    assign lanes[l].strb  = '0;
    assign gnt[l]         = lanes[l].gnt;
    assign rvalid[l]      = lanes[l].rvalid;
    assign rdata[l]       = lanes[l].rdata;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pend_q      <= '0;
      wait_q      <= '0;
      rsp_valid_q <= 1'b0;
    end else begin
      // Strobe the cycle after the last lane's data
      rsp_valid_q <= (|wait_q) && ((wait_q & ~rvalid) == '0);
      if (xfer) begin
        pend_q <= '1;
        wait_q <= '1;
      end else begin
        pend_q <= pend_q & ~gnt;
        wait_q <= wait_q & ~rvalid;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (xfer) begin
      addr_q <= addr_i;
    end
    // Gather each lane word into its slot
    for (int l = 0; l < LanesPerPort; l++) begin
      if (rvalid[l]) begin
        data_q[l] <= rdata[l];
      end
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_data_o  = data_q;

endmodule

// File: hw/wr_splitter.sv
`timescale 1ns/1ns

module wr_splitter #(
  parameter int unsigned  LanesPerPort = 2,
  localparam int unsigned AddrWidth    = bank_pkg::LaneAddrWidth - $clog2(LanesPerPort)
) (
  input  logic                                              clk_i,
  input  logic                                              rst_i,
  input  logic                                              valid_i,
  output logic                                              ready_o,
  input  logic [AddrWidth-1:0]                              addr_i,
  input  logic [LanesPerPort*bank_pkg::LaneDataWidth-1:0]   data_i,
  input  logic [LanesPerPort*bank_pkg::LaneDataWidth/8-1:0] strb_i,
  output logic                                              rsp_valid_o,
  lane_if.initiator                                         lanes [LanesPerPort]
);
  import bank_pkg::*;

  logic [AddrWidth-1:0]          addr_q;
  lane_data_t [LanesPerPort-1:0] data_q;
  lane_strb_t [LanesPerPort-1:0] strb_q;
  // Pending-grant mask, empty while idle
  logic [LanesPerPort-1:0]       pend_q;
  logic [LanesPerPort-1:0]       gnt;
  logic                          rsp_valid_q;
  logic                          xfer;

  assign ready_o = ~|pend_q;
  assign xfer    = valid_i & ready_o;

  for (genvar l = 0; l < LanesPerPort; l++) begin : gen_lane
    assign lanes[l].req   = pend_q[l];
    assign lanes[l].we    = 1'b1;
    assign lanes[l].addr  = lane_addr(LaneAddrWidth'(addr_q), l, LanesPerPort);
    assign lanes[l].wdata = data_q[l];
    assign lanes[l].strb  = strb_q[l];
    assign gnt[l]         = lanes[l].gnt;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pend_q      <= '0;
      rsp_valid_q <= 1'b0;
    end else begin
      // Done the cycle after the last grant
      rsp_valid_q <= (|pend_q) && ((pend_q & ~gnt) == '0);
      pend_q      <= xfer ? '1 : (pend_q & ~gnt);
    end
  end

  // Write payload held for the whole transaction
  always_ff @(posedge clk_i) begin
    if (xfer) begin
      addr_q <= addr_i;
      data_q <= data_i;
      strb_q <= strb_i;
    end
  end

  assign rsp_valid_o = rsp_valid_q;

endmodule

// File: hw/mem_banked_top.sv
`timescale 1ns/1ns

module mem_banked_top #(
  parameter int unsigned  NumBanks      = 4,
  parameter int unsigned  LanesPerPort  = 2,
  parameter int unsigned  BankAddrWidth = 5,
  localparam int unsigned AddrWidth     = bank_pkg::LaneAddrWidth - $clog2(LanesPerPort)
) (
  input  logic                                              clk_i,
  input  logic                                              rst_i,
  // Read port
  input  logic                                              rd_valid_i,
  output logic                                              rd_ready_o,
  input  logic [AddrWidth-1:0]                              rd_addr_i,
  output logic                                              rd_rsp_valid_o,
  output logic [LanesPerPort*bank_pkg::LaneDataWidth-1:0]   rd_rsp_data_o,
  // Write port
  input  logic                                              wr_valid_i,
  output logic                                              wr_ready_o,
  input  logic [AddrWidth-1:0]                              wr_addr_i,
  input  logic [LanesPerPort*bank_pkg::LaneDataWidth-1:0]   wr_data_i,
  input  logic [LanesPerPort*bank_pkg::LaneDataWidth/8-1:0] wr_strb_i,
  output logic                                              wr_rsp_valid_o
);
  import bank_pkg::*;

  // Lane traffic of each port
  lane_if rd_lanes [LanesPerPort] ();
  lane_if wr_lanes [LanesPerPort] ();

  // Crossbar to bank wiring
  logic       [NumBanks-1:0]                    bank_req;
  logic       [NumBanks-1:0]                    bank_we;
  logic       [NumBanks-1:0][BankAddrWidth-1:0] bank_row;
  lane_data_t [NumBanks-1:0]                    bank_wdata;
  lane_strb_t [NumBanks-1:0]                    bank_strb;
  lane_data_t [NumBanks-1:0]                    bank_rdata;

  rd_splitter #(
    .LanesPerPort ( LanesPerPort )
  ) i_rd_splitter (
    .clk_i,
    .rst_i,
    .valid_i     ( rd_valid_i     ),
    .ready_o     ( rd_ready_o     ),
    .addr_i      ( rd_addr_i      ),
    .rsp_valid_o ( rd_rsp_valid_o ),
    .rsp_data_o  ( rd_rsp_data_o  ),
    .lanes       ( rd_lanes       )
  );

  wr_splitter #(
    .LanesPerPort ( LanesPerPort )
  ) i_wr_splitter (
    .clk_i,
    .rst_i,
    .valid_i     ( wr_valid_i     ),
    .ready_o     ( wr_ready_o     ),
    .addr_i      ( wr_addr_i      ),
    .data_i      ( wr_data_i      ),
    .strb_i      ( wr_strb_i      ),
    .rsp_valid_o ( wr_rsp_valid_o ),
    .lanes       ( wr_lanes       )
  );

  bank_xbar #(
    .NumBanks      ( NumBanks      ),
    .LanesPerPort  ( LanesPerPort  ),
    .BankAddrWidth ( BankAddrWidth )
  ) i_bank_xbar (
    .clk_i,
    .rst_i,
    .rd_lanes     ( rd_lanes   ),
    .wr_lanes     ( wr_lanes   ),
    .bank_req_o   ( bank_req   ),
    .bank_we_o    ( bank_we    ),
    .bank_row_o   ( bank_row   ),
    .bank_wdata_o ( bank_wdata ),
    .bank_strb_o  ( bank_strb  ),
    .bank_rdata_i ( bank_rdata )
  );

  for (genvar b = 0; b < NumBanks; b++) begin : gen_bank
    bank_sram #(
      .BankAddrWidth ( BankAddrWidth )
    ) i_bank_sram (
      .clk_i,
      .req_i   ( bank_req[b]   ),
      .we_i    ( bank_we[b]    ),
      .row_i   ( bank_row[b]   ),
      .wdata_i ( bank_wdata[b] ),
      .strb_i  ( bank_strb[b]  ),
      .rdata_o ( bank_rdata[b] )
    );
  end

endmodule

// File: dv/tb_mem_model.svh
`ifndef TB_MEM_MODEL_SVH
`define TB_MEM_MODEL_SVH

// Reference memory, one entry per byte
// Byte index is lane address * 4 + byte within the lane
logic [7:0]           model_mem [NumWide*StrbWidth];
// Expected read data, queued at the read transfer
logic [DataWidth-1:0] rd_exp_q [$];
// Addresses of writes waiting for their response
logic [AddrWidth-1:0] wr_exp_q [$];

// Lane address from the wide address, as the banking rule forms it
function automatic int unsigned byte_index(input int unsigned wide_addr, input int unsigned k);
  int unsigned lane;
  lane = wide_addr * Lanes + k / 4;
  return lane * 4 + k % 4;
endfunction

task automatic store_bytes(input int unsigned addr, input logic [DataWidth-1:0] data,
                           input logic [StrbWidth-1:0] strb);
  for (int unsigned k = 0; k < StrbWidth; k++) begin
    // Disabled bytes keep their old value
    if (strb[k]) begin
      model_mem[byte_index(addr, k)] = data[8*k +: 8];
    end
  end
endtask

task automatic queue_read_expect(input int unsigned addr);
  logic [DataWidth-1:0] word;
  for (int unsigned k = 0; k < StrbWidth; k++) begin
    word[8*k +: 8] = model_mem[byte_index(addr, k)];
  end
  rd_exp_q.push_back(word);
endtask

`endif

// File: dv/tb_mem_banked.sv
`timescale 1ns/1ns

module tb_mem_banked;

  // Must match the DUT defaults
  localparam int unsigned Lanes         = 2;
  localparam int unsigned NumBanks      = 4;
  localparam int unsigned BankAddrWidth = 5;
  localparam int unsigned DataWidth     = Lanes * bank_pkg::LaneDataWidth;
  localparam int unsigned StrbWidth     = DataWidth / 8;
  localparam int unsigned AddrWidth     = bank_pkg::LaneAddrWidth - $clog2(Lanes);
  localparam int unsigned NumWide       = NumBanks * (2 ** BankAddrWidth) / Lanes;
  localparam int unsigned ClkPeriod     = 100;
  localparam int unsigned ResetCycles   = 8;
  // Transaction counts per phase
  localparam int unsigned PartialCount  = 60;
  localparam int unsigned CollideCount  = 40;
  localparam int unsigned RandomCount   = 150;
  // Requests per port over all phases
  localparam int unsigned PortTxn       = NumWide + PartialCount + CollideCount + RandomCount;
  localparam int unsigned NumTxn        = 2 * PortTxn;
  localparam int unsigned TimeoutCycles = NumTxn * 20 + ResetCycles;

  logic                 clk;
  logic                 rst;
  logic                 rd_valid;
  logic                 rd_ready;
  logic [AddrWidth-1:0] rd_addr;
  logic                 rd_rsp_valid;
  logic [DataWidth-1:0] rd_rsp_data;
  logic                 wr_valid;
  logic                 wr_ready;
  logic [AddrWidth-1:0] wr_addr;
  logic [DataWidth-1:0] wr_data;
  logic [StrbWidth-1:0] wr_strb;
  logic                 wr_rsp_valid;
  // Last address issued on each port and avoided by the other port
  int unsigned          rd_cur;
  int unsigned          wr_cur;
  int unsigned          rd_rsp_cnt;
  int unsigned          wr_rsp_cnt;

  `include "tb_mem_model.svh"

  mem_banked_top i_mem_banked_top (
    .clk_i          ( clk          ),
    .rst_i          ( rst          ),
    .rd_valid_i     ( rd_valid     ),
    .rd_ready_o     ( rd_ready     ),
    .rd_addr_i      ( rd_addr      ),
    .rd_rsp_valid_o ( rd_rsp_valid ),
    .rd_rsp_data_o  ( rd_rsp_data  ),
    .wr_valid_i     ( wr_valid     ),
    .wr_ready_o     ( wr_ready     ),
    .wr_addr_i      ( wr_addr      ),
    .wr_data_i      ( wr_data      ),
    .wr_strb_i      ( wr_strb      ),
    .wr_rsp_valid_o ( wr_rsp_valid )
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  // Ready is high exactly while idle and may already rise in the strobe cycle
  task automatic check_ready(input string name, input bit busy, input logic strobe,
                             input logic ready);
    logic exp;
    exp = !busy;
    if (!(busy && strobe === 1'b1)) begin
      assert (ready === exp)
        else stop_on_error($sformatf("MISMATCH %s expected %h actual %h", name, exp, ready));
    end
  endtask

  function automatic logic [DataWidth-1:0] random_word();
    return {$urandom, $urandom};
  endfunction

  task automatic drive_read(input int unsigned addr);
    rd_valid <= 1'b1;
    rd_addr  <= AddrWidth'(addr);
    rd_cur   = addr;
  endtask

  task automatic drive_write(input int unsigned addr, input logic [DataWidth-1:0] data,
                             input logic [StrbWidth-1:0] strb);
    wr_valid <= 1'b1;
    wr_addr  <= AddrWidth'(addr);
    wr_data  <= data;
    wr_strb  <= strb;
    wr_cur   = addr;
  endtask

  // Single write that returns on the edge after its response strobe
  task automatic write_word(input int unsigned addr, input logic [DataWidth-1:0] data,
                            input logic [StrbWidth-1:0] strb);
    drive_write(addr, data, strb);
    do @(negedge clk); while (wr_ready !== 1'b1);
    @(posedge clk);
    wr_valid <= 1'b0;
    while (wr_exp_q.size() != 0) @(posedge clk);
  endtask

  task automatic read_word(input int unsigned addr);
    drive_read(addr);
    do @(negedge clk); while (rd_ready !== 1'b1);
    @(posedge clk);
    rd_valid <= 1'b0;
    while (rd_exp_q.size() != 0) @(posedge clk);
  endtask

  // Traffic on both ports at once
  // In collide mode same parity pairs go out on the same edge
  task automatic run_mixed(input int unsigned n, input bit collide);
    int unsigned rd_left;
    int unsigned wr_left;
    int unsigned a;
    bit          rd_xfer;
    bit          wr_xfer;
    bit          rd_free;
    bit          wr_free;
    bit          done;
    rd_left = n;
    wr_left = n;
    done    = 1'b0;
    while (!done) begin
      @(negedge clk);
      rd_xfer = rd_valid && rd_ready === 1'b1;
      wr_xfer = wr_valid && wr_ready === 1'b1;
      @(posedge clk);
      // Every request issued, transferred and answered
      done = rd_left + wr_left == 0 && !rd_valid && !wr_valid &&
             rd_exp_q.size() == 0 && wr_exp_q.size() == 0;
      if (rd_xfer) rd_valid <= 1'b0;
      if (wr_xfer) wr_valid <= 1'b0;
      rd_free = rd_left != 0 && !rd_valid && rd_exp_q.size() == 0;
      wr_free = wr_left != 0 && !wr_valid && wr_exp_q.size() == 0;
      if (collide) begin
        // Same parity wide addresses map onto the same two banks
        if (rd_free && wr_free) begin
          a = $urandom_range(NumWide - 1);
          drive_read(a);
          drive_write((a + 2 * $urandom_range(NumWide / 2 - 1, 1)) % NumWide, random_word(), '1);
          rd_left--;
          wr_left--;
        end
      end else begin
        // Random gaps of about one idle cycle in four
        if (wr_free && $urandom_range(3) != 0) begin
          do a = $urandom_range(NumWide - 1); while (a == rd_cur);
          drive_write(a, random_word(), StrbWidth'($urandom));
          wr_left--;
        end
        if (rd_free && $urandom_range(3) != 0) begin
          do a = $urandom_range(NumWide - 1); while (a == wr_cur);
          drive_read(a);
          rd_left--;
        end
      end
    end
  endtask

  // Response and ready monitor at the falling edge where outputs are stable
  always @(negedge clk) begin
    logic [DataWidth-1:0] exp;
    if (!rst) begin
      check_ready("rd_ready_o", rd_exp_q.size() != 0, rd_rsp_valid, rd_ready);
      check_ready("wr_ready_o", wr_exp_q.size() != 0, wr_rsp_valid, wr_ready);
      if (rd_rsp_valid === 1'b1) begin
        assert (rd_exp_q.size() != 0)
          else stop_on_error("Read response strobe with no read in flight");
        exp = rd_exp_q.pop_front();
        assert (rd_rsp_data === exp)
          else stop_on_error($sformatf("MISMATCH rd_rsp_data_o expected %h actual %h",
                                       exp, rd_rsp_data));
        rd_rsp_cnt++;
      end
      if (wr_rsp_valid === 1'b1) begin
        assert (wr_exp_q.size() != 0)
          else stop_on_error("Write response strobe with no write in flight");
        void'(wr_exp_q.pop_front());
        wr_rsp_cnt++;
      end
      // Transfers take place on the coming rising edge
      if (rd_valid && rd_ready === 1'b1) begin
        queue_read_expect(32'(rd_addr));
      end
      if (wr_valid && wr_ready === 1'b1) begin
        store_bytes(32'(wr_addr), wr_data, wr_strb);
        wr_exp_q.push_back(wr_addr);
      end
    end
  end

  initial begin
    #(TimeoutCycles * ClkPeriod);
    stop_on_error($sformatf("Timeout, run not finished after %0d cycles", TimeoutCycles));
  end

  initial begin
    int unsigned a;
    void'($urandom(69));
    rst      <= 1'b1;
    rd_valid <= 1'b0;
    rd_addr  <= '0;
    wr_valid <= 1'b0;
    wr_addr  <= '0;
    wr_data  <= '0;
    wr_strb  <= '0;
    rd_cur     = NumWide;
    wr_cur     = NumWide;
    rd_rsp_cnt = 0;
    wr_rsp_cnt = 0;
    repeat (ResetCycles) @(posedge clk);
    rst <= 1'b0;
    // Idle after reset
    repeat (4) begin
      @(negedge clk);
      assert (rd_ready === 1'b1 && wr_ready === 1'b1)
        else stop_on_error("A port is not ready after reset");
      assert (rd_rsp_valid === 1'b0 && wr_rsp_valid === 1'b0)
        else stop_on_error("Response strobe after reset with no request");
    end
    @(posedge clk);
    // Full strobe fill of every wide word before the read back
    for (int unsigned i = 0; i < NumWide; i++) begin
      write_word(i, random_word(), '1);
    end
    for (int unsigned i = 0; i < NumWide; i++) begin
      read_word(i);
    end
    // Partial strobes over written words
    repeat (PartialCount) begin
      a = $urandom_range(NumWide - 1);
      write_word(a, random_word(), StrbWidth'($urandom));
      read_word(a);
    end
    run_mixed(CollideCount, 1'b1);
    run_mixed(RandomCount, 1'b0);
    repeat (4) @(posedge clk);
    assert (rd_rsp_cnt == PortTxn)
      else stop_on_error($sformatf("MISMATCH rd_rsp_valid_o count expected %h actual %h",
                                   PortTxn, rd_rsp_cnt));
    assert (wr_rsp_cnt == PortTxn)
      else stop_on_error($sformatf("MISMATCH wr_rsp_valid_o count expected %h actual %h",
                                   PortTxn, wr_rsp_cnt));
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

// File: src.f
+incdir+dv
hw/bank_pkg.sv
hw/lane_if.sv
hw/bank_sram.sv
hw/bank_xbar.sv
hw/rd_splitter.sv
hw/wr_splitter.sv
hw/mem_banked_top.sv
dv/tb_mem_banked.sv

// File: Makefile
TOP := tb_mem_banked
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f src.f --top-module $(TOP)

sim:
	verilator --binary --timing -j 0 -f src.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then \
	  echo "Simulation failed"; exit 1; \
	fi
	@grep -q "ALL TESTS PASSED" $(LOG) || (echo "Simulation ended early"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
